/* Makefile */
VERILATOR ?= verilator
TOP       ?= regex_req_tb
FILELIST  ?= regex_req_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the result, the simulator exit status is not used
run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "Done: no errors" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* regex_req_top.f */
src/rdma_pkg.sv
src/regex_pkg.sv
src/out_slot.sv
src/cnfg_beat_counter.sv
src/cnfg_assembler.sv
src/regex_req_fsm.sv
src/regex_req_top.sv
verif/regex_req_tb.sv

/* src/cnfg_assembler.sv */
`default_nettype none

module cnfg_assembler #(
    parameter int CNFG_BEATS = 3
) (
    input  logic                          aclk,
    input  logic                          aresetn,
    input  logic                          we,
    input  logic [1:0]                    index,
    input  logic [rdma_pkg::MSG_BITS-1:0] beat,
    output regex_pkg::cnfg_word_t         word
);
    import rdma_pkg::*;
    import regex_pkg::*;

    logic [MSG_BITS-1:0] beats [CNFG_BEATS];

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < CNFG_BEATS; i++) begin
                beats[i] <= '0;
            end
        end else if (we) begin
            for (int i = 0; i < CNFG_BEATS; i++) begin
                if (index == 2'(i)) begin
                    beats[i] <= beat;
                end else if (index == 2'd0) begin
                    beats[i] <= '0;
                end
            end
        end
    end

    // Current beat bypasses the store so the last one lands in the slot
    always_comb begin
        word = '0;
        word[CNFG_VALID_BIT] = 1'b1;
        for (int i = 0; i < CNFG_BEATS; i++) begin
            if (we && index == 2'(i)) begin
                word[(CNFG_BEATS-1-i)*MSG_BITS +: MSG_BITS] = beat;
            end else if (we && index == 2'd0) begin
                word[(CNFG_BEATS-1-i)*MSG_BITS +: MSG_BITS] = '0;
            end else begin
                word[(CNFG_BEATS-1-i)*MSG_BITS +: MSG_BITS] = beats[i];
            end
        end
    end

endmodule

`default_nettype wire

/* src/cnfg_beat_counter.sv */
`default_nettype none

module cnfg_beat_counter #(
    parameter int CNFG_BEATS = 3
) (
    input  logic       aclk,
    input  logic       aresetn,
    input  logic       start,
    input  logic       step,
    output logic [1:0] index,
    output logic       last
);
    localparam logic [1:0] LAST_IDX = 2'(CNFG_BEATS - 1);

    logic [1:0] base;

    // A new sequence always counts from its first beat
    assign base = start ? 2'd0 : index;
    assign last = (index == LAST_IDX);

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            index <= 2'd0;
        end else if (step) begin
            if (base == LAST_IDX) begin
                index <= 2'd0;
            end else begin
                index <= base + 2'd1;
            end
        end
    end

    assert property (@(posedge aclk) disable iff (!aresetn)
        index <= LAST_IDX);

endmodule

`default_nettype wire

/* src/out_slot.sv */
`default_nettype none

module out_slot #(
    parameter type payload_t = logic
) (
    input  logic     aclk,
    input  logic     aresetn,
    input  logic     load,
    input  payload_t in_data,
    input  logic     ready,
    output logic     valid,
    output payload_t data
);

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            valid <= 1'b0;
        end else if (load) begin
            valid <= 1'b1;
        end else if (ready) begin
            valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (load) begin
            data <= in_data;
        end
    end

    // Never overwrite an item that has not been taken
    assert property (@(posedge aclk) disable iff (!aresetn)
        load |-> !(valid && !ready));

    // Held item stays put until the receiver takes it
    assert property (@(posedge aclk) disable iff (!aresetn)
        (valid && !ready) |=> (valid && $stable(data)));

endmodule

`default_nettype wire

/* src/rdma_pkg.sv */
`default_nettype none

package rdma_pkg;

    // Queue pair number carried with every message
    localparam int QPN_BITS = 24;

    // Local and remote buffer addresses
    localparam int VADDR_BITS = 48;

    localparam int LEN_BITS = 28;

    // Free-form parameter field of the message header
    localparam int PARAMS_BITS = 64;

    // Raw payload, also one configuration beat
    localparam int MSG_BITS = 128;

    // Parameter bit that opens a configuration sequence
    localparam int PARAM_CNFG_BIT = 0;

endpackage

`default_nettype wire

/* src/regex_pkg.sv */
`default_nettype none

package regex_pkg;

    // Matcher configuration word
    localparam int CNFG_BITS = 512;
    localparam int CNFG_VALID_BIT = 511;

    // Queue pair sits above the remote address
    localparam int SEQ_PARAMS_BITS = rdma_pkg::QPN_BITS + rdma_pkg::VADDR_BITS;

    // Host read of the local buffer
    typedef struct packed {
        logic [rdma_pkg::VADDR_BITS-1:0] vaddr;
        logic [rdma_pkg::LEN_BITS-1:0]   len;
    } rd_req_t;

    typedef logic [SEQ_PARAMS_BITS-1:0] seq_params_t;

    typedef logic [CNFG_BITS-1:0] cnfg_word_t;

endpackage

`default_nettype wire

/* src/regex_req_fsm.sv */
`default_nettype none

module regex_req_fsm #(
    parameter int CNFG_BEATS = 3
) (
    input  logic                             aclk,
    input  logic                             aresetn,
    input  logic                             fv_valid,
    input  logic [rdma_pkg::PARAMS_BITS-1:0] fv_params,
    input  logic                             beat_last,
    input  logic                             rd_busy,
    input  logic                             cnfg_busy,
    output logic                             fv_ready,
    output logic                             beat_start,
    output logic                             beat_step,
    output logic                             beat_we,
    output logic                             rd_load,
    output logic                             cnfg_load
);
    import rdma_pkg::*;

    typedef enum logic {IDLE, COLLECT} state_t;

    state_t state;
    state_t state_next;
    logic   is_cnfg;
    logic   cnfg_accept;
    logic   rd_accept;

    assign is_cnfg = fv_params[PARAM_CNFG_BIT];

    // Only the last beat of a sequence needs room in the cnfg slot
    always_comb begin
        cnfg_accept = 1'b0;
        rd_accept   = 1'b0;
        state_next  = state;
        case (state)
            IDLE: begin
                if (fv_valid) begin
                    if (is_cnfg) begin
                        cnfg_accept = !beat_last || !cnfg_busy;
                        if (cnfg_accept && !beat_last) begin
                            state_next = COLLECT;
                        end
                    end else begin
                        rd_accept = !rd_busy;
                    end
                end
            end
            COLLECT: begin
                if (fv_valid) begin
                    cnfg_accept = !beat_last || !cnfg_busy;
                    if (cnfg_accept && beat_last) begin
                        state_next = IDLE;
                    end
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign fv_ready   = cnfg_accept || rd_accept;
    assign beat_start = cnfg_accept && (state == IDLE);
    assign beat_step  = cnfg_accept;
    assign beat_we    = cnfg_accept;
    assign rd_load    = rd_accept;
    assign cnfg_load  = cnfg_accept && beat_last;

    // A load goes into an empty slot, which then shows as busy
    assert property (@(posedge aclk) disable iff (!aresetn)
        rd_load |-> !rd_busy ##1 rd_busy);
    assert property (@(posedge aclk) disable iff (!aresetn)
        cnfg_load |-> !cnfg_busy ##1 cnfg_busy);

    assert property (@(posedge aclk) disable iff (!aresetn)
        beat_we |-> fv_valid && fv_ready);

    // Counter sits at beat zero whenever no sequence is open
    assert property (@(posedge aclk) disable iff (!aresetn)
        (state == IDLE) |-> (beat_last == (CNFG_BEATS == 1)));

endmodule

`default_nettype wire

/* src/regex_req_top.sv */
`default_nettype none

module regex_req_top #(
    parameter int CNFG_BEATS = 3
) (
    input  logic                             aclk,
    input  logic                             aresetn,

    // RDMA receive stream
    input  logic                             fv_valid,
    output logic                             fv_ready,
    input  logic [rdma_pkg::QPN_BITS-1:0]    fv_qpn,
    input  logic [rdma_pkg::VADDR_BITS-1:0]  fv_lvaddr,
    input  logic [rdma_pkg::VADDR_BITS-1:0]  fv_rvaddr,
    input  logic [rdma_pkg::LEN_BITS-1:0]    fv_len,
    input  logic [rdma_pkg::PARAMS_BITS-1:0] fv_params,
    input  logic [rdma_pkg::MSG_BITS-1:0]    fv_msg,

    // Host read
    output logic                             rd_valid,
    input  logic                             rd_ready,
    output logic [rdma_pkg::VADDR_BITS-1:0]  rd_vaddr,
    output logic [rdma_pkg::LEN_BITS-1:0]    rd_len,

    // Sequencer parameters
    output logic                             params_valid,
    input  logic                             params_ready,
    output regex_pkg::seq_params_t           params_data,

    // Matcher configuration
    output logic                             cnfg_valid,
    input  logic                             cnfg_ready,
    output regex_pkg::cnfg_word_t            cnfg_data
);
    import regex_pkg::*;

    logic        beat_start;
    logic        beat_step;
    logic        beat_we;
    logic        beat_last;
    logic [1:0]  beat_index;
    logic        rd_load;
    logic        cnfg_load;
    logic        rd_busy;
    rd_req_t     rd_in;
    rd_req_t     rd_out;
    seq_params_t params_in;
    cnfg_word_t  cnfg_word;

    // Both read outputs must drain before the next read
    assign rd_busy   = rd_valid || params_valid;
    assign rd_in.vaddr = fv_lvaddr;
    assign rd_in.len   = fv_len;
    assign params_in = {fv_qpn, fv_rvaddr};
    assign rd_vaddr  = rd_out.vaddr;
    assign rd_len    = rd_out.len;

    regex_req_fsm #(
        .CNFG_BEATS (CNFG_BEATS)
    ) fsm (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .fv_valid   (fv_valid),
        .fv_params  (fv_params),
        .beat_last  (beat_last),
        .rd_busy    (rd_busy),
        .cnfg_busy  (cnfg_valid),
        .fv_ready   (fv_ready),
        .beat_start (beat_start),
        .beat_step  (beat_step),
        .beat_we    (beat_we),
        .rd_load    (rd_load),
        .cnfg_load  (cnfg_load)
    );

    cnfg_beat_counter #(
        .CNFG_BEATS (CNFG_BEATS)
    ) beat_counter (
        .aclk    (aclk),
        .aresetn (aresetn),
        .start   (beat_start),
        .step    (beat_step),
        .index   (beat_index),
        .last    (beat_last)
    );

    cnfg_assembler #(
        .CNFG_BEATS (CNFG_BEATS)
    ) assembler (
        .aclk    (aclk),
        .aresetn (aresetn),
        .we      (beat_we),
        .index   (beat_index),
        .beat    (fv_msg),
        .word    (cnfg_word)
    );

    out_slot #(
        .payload_t (rd_req_t)
    ) rd_slot (
        .aclk    (aclk),
        .aresetn (aresetn),
        .load    (rd_load),
        .in_data (rd_in),
        .ready   (rd_ready),
        .valid   (rd_valid),
        .data    (rd_out)
    );

    out_slot #(
        .payload_t (seq_params_t)
    ) params_slot (
        .aclk    (aclk),
        .aresetn (aresetn),
        .load    (rd_load),
        .in_data (params_in),
        .ready   (params_ready),
        .valid   (params_valid),
        .data    (params_data)
    );

    out_slot #(
        .payload_t (cnfg_word_t)
    ) cnfg_slot (
        .aclk    (aclk),
        .aresetn (aresetn),
        .load    (cnfg_load),
        .in_data (cnfg_word),
        .ready   (cnfg_ready),
        .valid   (cnfg_valid),
        .data    (cnfg_data)
    );

endmodule

`default_nettype wire

/* verif/regex_req_tb.sv */
`default_nettype none

module regex_req_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import rdma_pkg::*;
    import regex_pkg::*;

    localparam int TIMEOUT = 200;

    typedef struct packed {
        logic                  is_cnfg;
        logic                  stall;
        logic [QPN_BITS-1:0]   qpn;
        logic [VADDR_BITS-1:0] lvaddr;
        logic [VADDR_BITS-1:0] rvaddr;
        logic [LEN_BITS-1:0]   len;
        logic [MSG_BITS-1:0]   b0;
        logic [MSG_BITS-1:0]   b1;
        logic [MSG_BITS-1:0]   b2;
        rd_req_t               exp_rd;
        seq_params_t           exp_params;
        cnfg_word_t            exp_cnfg;
    } entry_t;

    logic                  aclk;
    logic                  aresetn;
    logic                  fv_valid;
    logic                  fv_ready;
    logic [QPN_BITS-1:0]   fv_qpn;
    logic [VADDR_BITS-1:0] fv_lvaddr;
    logic [VADDR_BITS-1:0] fv_rvaddr;
    logic [LEN_BITS-1:0]   fv_len;
    logic [PARAMS_BITS-1:0] fv_params;
    logic [MSG_BITS-1:0]   fv_msg;
    logic                  rd_valid;
    logic                  rd_ready;
    logic [VADDR_BITS-1:0] rd_vaddr;
    logic [LEN_BITS-1:0]   rd_len;
    logic                  params_valid;
    logic                  params_ready;
    seq_params_t           params_data;
    logic                  cnfg_valid;
    logic                  cnfg_ready;
    cnfg_word_t            cnfg_data;

    entry_t      table_q[$];
    rd_req_t     exp_rd_q[$];
    seq_params_t exp_params_q[$];
    cnfg_word_t  exp_cnfg_q[$];
    logic [31:0] lfsr;
    logic        rd_stall;
    logic        cur_is_read;
    logic        cur_last;
    logic        rd_held;
    logic        params_held;
    logic        cnfg_held;
    logic [511:0] rd_prev;
    logic [511:0] params_prev;
    logic [511:0] cnfg_prev;

    regex_req_top #(
        .CNFG_BEATS (3)
    ) DUT (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .fv_valid     (fv_valid),
        .fv_ready     (fv_ready),
        .fv_qpn       (fv_qpn),
        .fv_lvaddr    (fv_lvaddr),
        .fv_rvaddr    (fv_rvaddr),
        .fv_len       (fv_len),
        .fv_params    (fv_params),
        .fv_msg       (fv_msg),
        .rd_valid     (rd_valid),
        .rd_ready     (rd_ready),
        .rd_vaddr     (rd_vaddr),
        .rd_len       (rd_len),
        .params_valid (params_valid),
        .params_ready (params_ready),
        .params_data  (params_data),
        .cnfg_valid   (cnfg_valid),
        .cnfg_ready   (cnfg_ready),
        .cnfg_data    (cnfg_data)
    );

    initial begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Valid flag on top, gap at zero, first beat highest
    function automatic cnfg_word_t cnfg_expect(input logic [MSG_BITS-1:0] b0, b1, b2);
        cnfg_word_t w;
        w = '0;
        w[511] = 1'b1;
        w[383:256] = b0;
        w[255:128] = b1;
        w[127:0] = b2;
        return w;
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic drive_readies();
        lfsr = lfsr_next(lfsr);
        rd_ready = lfsr[0] && !rd_stall;
        lfsr = lfsr_next(lfsr);
        params_ready = lfsr[0] && !rd_stall;
        lfsr = lfsr_next(lfsr);
        cnfg_ready = lfsr[0];
    endtask

    task automatic tick();
        @(posedge aclk);
        #10;
        drive_readies();
    endtask

    task automatic add_read(input logic [QPN_BITS-1:0] qpn, input logic [VADDR_BITS-1:0] lv,
                            input logic [VADDR_BITS-1:0] rv, input logic [LEN_BITS-1:0] len,
                            input rd_req_t exp_rd, input seq_params_t exp_params);
        entry_t e;
        e = '0;
        e.qpn = qpn;
        e.lvaddr = lv;
        e.rvaddr = rv;
        e.len = len;
        e.exp_rd = exp_rd;
        e.exp_params = exp_params;
        table_q.push_back(e);
    endtask

    task automatic add_cnfg(input logic stall, input logic [MSG_BITS-1:0] b0, b1, b2);
        entry_t e;
        e = '0;
        e.is_cnfg = 1'b1;
        e.stall = stall;
        e.b0 = b0;
        e.b1 = b1;
        e.b2 = b2;
        e.exp_cnfg = cnfg_expect(b0, b1, b2);
        table_q.push_back(e);
    endtask

    task automatic build_table();
        add_read(24'h00_0a01, 48'h0000_1000_0040, 48'h7f00_2000_0000, 28'h000_0200,
                 {48'h0000_1000_0040, 28'h000_0200}, {24'h00_0a01, 48'h7f00_2000_0000});
        add_cnfg(1'b0, {4{32'hc1c1_0000}}, {4{32'hc1c1_0001}}, {4{32'hc1c1_0002}});
        add_cnfg(1'b0, {4{32'hc2c2_0000}}, {4{32'hc2c2_0001}}, {4{32'hc2c2_0002}});
        add_read(24'h00_0a02, 48'h0000_1000_1000, 48'h7f00_2000_8000, 28'h000_0040,
                 {48'h0000_1000_1000, 28'h000_0040}, {24'h00_0a02, 48'h7f00_2000_8000});
        // Runs while the read above is held in its slots
        add_cnfg(1'b1, {4{32'hc3c3_0000}}, {4{32'hc3c3_0001}}, {4{32'hc3c3_0002}});
        add_read(24'h12_3456, 48'h0abc_def0_1230, 48'h0000_0000_0008, 28'hfff_ffff,
                 {48'h0abc_def0_1230, 28'hfff_ffff}, {24'h12_3456, 48'h0000_0000_0008});
        add_read(24'hff_ffff, 48'hffff_ffff_fff0, 48'h8000_0000_0001, 28'h000_0001,
                 {48'hffff_ffff_fff0, 28'h000_0001}, {24'hff_ffff, 48'h8000_0000_0001});
        add_cnfg(1'b0, {4{32'hc4c4_0000}}, {4{32'hc4c4_0001}}, {4{32'hc4c4_0002}});
        add_read(24'h00_0007, 48'h0000_0000_0000, 48'hffff_ffff_ffff, 28'h800_0000,
                 {48'h0000_0000_0000, 28'h800_0000}, {24'h00_0007, 48'hffff_ffff_ffff});
        add_cnfg(1'b0, {4{32'hc5c5_0000}}, {4{32'hc5c5_0001}}, {4{32'hc5c5_0002}});
        add_cnfg(1'b0, {4{32'hc6c6_0000}}, {4{32'hc6c6_0001}}, {4{32'hc6c6_0002}});
        add_read(24'h5a_5a5a, 48'h1234_5678_9abc, 48'hcafe_0000_beef, 28'h0ab_cdef,
                 {48'h1234_5678_9abc, 28'h0ab_cdef}, {24'h5a_5a5a, 48'hcafe_0000_beef});
    endtask

    task automatic send_beat(input logic [PARAMS_BITS-1:0] params,
                             input logic [MSG_BITS-1:0] msg, input logic last);
        int   waited;
        logic taken;
        waited = 0;
        taken = 1'b0;
        fv_params = params;
        fv_msg = msg;
        cur_last = last;
        fv_valid = 1'b1;
        while (!taken) begin
            @(negedge aclk);
            taken = fv_ready;
            tick();
            waited++;
            if (!taken && waited >= TIMEOUT) begin
                fail_now("Timeout: a message was never accepted");
            end
        end
        fv_valid = 1'b0;
    endtask

    task automatic run_entry(input entry_t e);
        if (e.is_cnfg) begin
            exp_cnfg_q.push_back(e.exp_cnfg);
            cur_is_read = 1'b0;
            if (e.stall) begin
                rd_stall = 1'b1;
                rd_ready = 1'b0;
                params_ready = 1'b0;
            end
            send_beat(64'h1, e.b0, 1'b0);
            send_beat(64'h0, e.b1, 1'b0);
            send_beat(64'h0, e.b2, 1'b1);
            // One cycle from the last beat to a valid word
            assert (cnfg_valid) else
                fail_now($sformatf("FAILED at %0t: cnfg_valid low after the last beat", $time));
            if (e.stall) begin
                assert (rd_valid && params_valid) else
                    fail_now("The pending read left its slots while its receivers were stalled");
                rd_stall = 1'b0;
            end
        end else begin
            exp_rd_q.push_back(e.exp_rd);
            exp_params_q.push_back(e.exp_params);
            cur_is_read = 1'b1;
            fv_qpn = e.qpn;
            fv_lvaddr = e.lvaddr;
            fv_rvaddr = e.rvaddr;
            fv_len = e.len;
            send_beat(64'h2, '0, 1'b1);
            assert (rd_valid && params_valid) else
                fail_now($sformatf("FAILED at %0t: read outputs not valid after acceptance",
                    $time));
        end
    endtask

    task automatic check_hold(input string name, input logic valid, input logic ready,
                              input logic [511:0] data, inout logic held,
                              inout logic [511:0] prev);
        if (held) begin
            assert (valid && data == prev) else
                fail_now($sformatf("FAILED at %0t: %s item changed before its transfer",
                    $time, name));
        end
        held = valid && !ready;
        prev = data;
    endtask

    // Sampled mid-cycle ahead of each transfer edge
    always @(negedge aclk) begin
        if (aresetn) begin
            if (fv_valid) begin
                assert (fv_ready == (cur_is_read ? !(rd_valid || params_valid)
                                                 : (!cur_last || !cnfg_valid))) else
                    fail_now($sformatf("FAILED at %0t: fv_ready is %0b against the accept rule",
                        $time, fv_ready));
            end
            check_hold("rd", rd_valid, rd_ready, 512'({rd_vaddr, rd_len}), rd_held, rd_prev);
            check_hold("params", params_valid, params_ready, 512'(params_data),
                       params_held, params_prev);
            check_hold("cnfg", cnfg_valid, cnfg_ready, cnfg_data, cnfg_held, cnfg_prev);
            if (rd_valid && rd_ready) begin
                assert (exp_rd_q.size() > 0) else fail_now("Extra rd transfer with no read sent");
                assert ({rd_vaddr, rd_len} == exp_rd_q[0]) else
                    fail_now($sformatf("FAILED at %0t: rd got %h, expected %h",
                        $time, {rd_vaddr, rd_len}, exp_rd_q[0]));
                void'(exp_rd_q.pop_front());
            end
            if (params_valid && params_ready) begin
                assert (exp_params_q.size() > 0) else fail_now("Extra params transfer");
                assert (params_data == exp_params_q[0]) else
                    fail_now($sformatf("FAILED at %0t: params got %h, expected %h",
                        $time, params_data, exp_params_q[0]));
                void'(exp_params_q.pop_front());
            end
            if (cnfg_valid && cnfg_ready) begin
                assert (exp_cnfg_q.size() > 0) else fail_now("Extra cnfg transfer");
                assert (cnfg_data == exp_cnfg_q[0]) else
                    fail_now($sformatf("FAILED at %0t: cnfg got %h, expected %h",
                        $time, cnfg_data, exp_cnfg_q[0]));
                void'(exp_cnfg_q.pop_front());
            end
        end
    end

    initial begin
        int waited;
        aresetn = 1'b0;
        fv_valid = 1'b0;
        fv_qpn = '0;
        fv_lvaddr = '0;
        fv_rvaddr = '0;
        fv_len = '0;
        fv_params = '0;
        fv_msg = '0;
        rd_ready = 1'b0;
        params_ready = 1'b0;
        cnfg_ready = 1'b0;
        rd_stall = 1'b0;
        cur_is_read = 1'b0;
        cur_last = 1'b0;
        rd_held = 1'b0;
        params_held = 1'b0;
        cnfg_held = 1'b0;
        rd_prev = '0;
        params_prev = '0;
        cnfg_prev = '0;
        lfsr = 32'hbbb7_4ff1;
        build_table();
        repeat (8) @(posedge aclk);
        #10;
        aresetn = 1'b1;
        assert (!rd_valid && !params_valid && !cnfg_valid) else
            fail_now("An output valid is high right after reset");
        drive_readies();
        foreach (table_q[i]) begin
            run_entry(table_q[i]);
        end
        waited = 0;
        while (exp_rd_q.size() + exp_params_q.size() + exp_cnfg_q.size() > 0) begin
            tick();
            waited++;
            if (waited >= TIMEOUT) begin
                fail_now("Timeout: expected output words never arrived");
            end
        end
        assert (!rd_valid && !params_valid && !cnfg_valid) else
            fail_now("An output is still valid after all expected words were taken");
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire
